// ==== logic/obj_pkg.sv ====
/*
  Shared types and constants for the object line renderer.
  Holds the table entry, the scanner-to-drawer job, the line buffer
  write record, the FSM state encodings and the visible window.
  Modules pull it in with a wildcard import in their header.
*/
package obj_pkg;

    // ==================================================
    // Records
    // ==================================================

    // One object table entry, 42 bits
    typedef struct packed {
        logic [15:0] code;
        logic [8:0]  vpos;   // top line of the 16-line tile
        logic [8:0]  hpos;   // left pixel
        logic        hflip;
        logic [4:0]  pal;
        logic [1:0]  bank;
    } obj_entry_t;

    // Object picked for the current line
    typedef struct packed {
        logic [15:0] code;
        logic [3:0]  vsub;   // row inside the tile
        logic [8:0]  hpos;
        logic        hflip;
        logic [4:0]  pal;
        logic [1:0]  bank;
    } obj_job_t;

    // Pixel write, pal in data[8:4] and colour in data[3:0]
    typedef struct packed {
        logic [8:0] addr;
        logic [8:0] data;
    } buf_wr_t;

    // ==================================================
    // FSM states
    // ==================================================

    typedef enum logic [1:0] {
        scan_idle,
        scan_read,
        scan_test,
        scan_wait_draw
    } scan_state_t;

    typedef enum logic [1:0] {
        draw_idle,
        draw_fetch,
        draw_pixel
    } draw_state_t;

    // Objects are drawn only with hpos strictly inside this window
    localparam logic [8:0] hpos_min = 9'h30;
    localparam logic [8:0] hpos_max = 9'h1c0;

    localparam logic [3:0] colour_clear = 4'hf;

endpackage

// ==== logic/obj_scan.sv ====
/*
  Object table and line scanner.
  The host fills the table one entry per strobe. On line_start the
  scanner walks every entry, hands objects that cross the line to the
  drawer one at a time and pulses line_done once the drawer is idle
  after the last entry.
*/
module obj_scan
    import obj_pkg::*;
#(
    parameter int obj_count = 16,
    localparam int idx_w = $clog2(obj_count)
) (
    input  logic             clk,
    input  logic             rst,

    // Host side
    input  logic             tbl_wr,
    input  logic [idx_w-1:0] tbl_idx,
    input  obj_entry_t       tbl_entry,
    input  logic             line_start,
    input  logic [8:0]       line,

    // Drawer side
    input  logic             idle,
    output logic             start,
    output obj_job_t         job,
    output logic             line_done
);

    obj_entry_t       tbl [obj_count];
    scan_state_t      state;
    logic [idx_w-1:0] idx;
    logic [idx_w-1:0] idx_next;
    logic [8:0]       line_q;
    obj_entry_t       cur;
    logic [8:0]       vdiff;
    logic             hit;
    logic             last;

    assign idx_next = idx + 1'b1;
    assign last     = (idx == idx_w'(obj_count - 1));

    // Row inside the tile, wraps modulo 512 like the line counter
    assign vdiff = line_q - cur.vpos;
    assign hit   = (vdiff[8:4] == 5'd0);

    always_ff @(posedge clk) begin
        if (tbl_wr) begin
            tbl[tbl_idx] <= tbl_entry;
        end
    end

    // ==================================================
    // Scan FSM
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= scan_idle;
            idx       <= '0;
            start     <= 1'b0;
            line_done <= 1'b0;
        end else begin
            start     <= 1'b0;
            line_done <= 1'b0;
            case (state)
                scan_idle: begin
                    if (line_start) begin
                        idx   <= '0;
                        state <= scan_read;
                    end
                end
                scan_read: begin
                    state <= scan_test;
                end
                scan_test: begin
                    if (hit) begin
                        if (idle) begin
                            start <= 1'b1;
                            state <= scan_wait_draw;
                        end
                    end else if (last) begin
                        line_done <= 1'b1;
                        state     <= scan_idle;
                    end else begin
                        // Misses move on one entry per cycle
                        idx <= idx_next;
                    end
                end
                scan_wait_draw: begin
                    // idle is stale in the cycle start is high
                    if (!start && idle) begin
                        if (last) begin
                            line_done <= 1'b1;
                            state     <= scan_idle;
                        end else begin
                            idx   <= idx_next;
                            state <= scan_read;
                        end
                    end
                end
                default: begin
                    state <= scan_idle;
                end
            endcase
        end
    end

    // Line latch, entry fetch and job build
    always_ff @(posedge clk) begin
        if (state == scan_idle && line_start) begin
            line_q <= line;
        end
        if (state == scan_read) begin
            cur <= tbl[idx];
        end else if (state == scan_test && !hit && !last) begin
            cur <= tbl[idx_next];
        end
        if (state == scan_test && hit) begin
            job.code  <= cur.code;
            job.vsub  <= vdiff[3:0];
            job.hpos  <= cur.hpos;
            job.hflip <= cur.hflip;
            job.pal   <= cur.pal;
            job.bank  <= cur.bank;
        end
    end

    // A new line must wait for line_done of the previous one
    assert property (@(posedge clk) disable iff (rst) line_start |-> state == scan_idle)
        else $error("line_start arrived while the scan was busy");

endmodule

// ==== logic/obj_draw.sv ====
/*
  Tile row drawer.
  Takes one job from the scanner, reads the two 32-bit halves of the
  tile row from graphics ROM and writes 8 pixels per half into the line
  buffer, one per cycle. All-ones words are skipped. Jobs with hpos
  outside the visible window are dropped and idle stays high.
*/
module obj_draw
    import obj_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Scanner side
    input  obj_job_t    job,
    input  logic        start,
    output logic        idle,

    // Line buffer
    output buf_wr_t     wr,
    output logic        wr_en,

    // Graphics ROM
    output logic [19:0] rom_addr,
    output logic [1:0]  rom_bank,
    output logic        rom_half,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok
);

    draw_state_t state;
    logic [1:0]  hold;      // blanks rom_ok after each new address
    logic        second;    // working on the second half
    logic [3:0]  cnt;
    logic [31:0] pix;
    logic [8:0]  addr;
    logic [4:0]  pal;
    logic        hflip;

    logic        in_window;
    logic        accept;
    logic        rom_good;
    logic        fetch_ok;
    logic        blank;
    logic        emit;

    // Four pixel planes, one bit per byte of the word
    function automatic logic [3:0] pick_colour(input logic [31:0] w, input logic flip);
        logic [3:0] c;
        if (flip) begin
            c = {w[24], w[16], w[8], w[0]};
        end else begin
            c = {w[31], w[23], w[15], w[7]};
        end
        return c;
    endfunction

    assign in_window = (job.hpos > hpos_min) && (job.hpos < hpos_max);
    assign accept    = (state == draw_idle) && start && in_window;
    assign rom_good  = rom_ok && (hold == 2'b00);
    assign fetch_ok  = (state == draw_fetch) && rom_good;
    assign blank     = &rom_data;
    assign emit      = (state == draw_pixel) && !cnt[3];
    assign idle      = (state == draw_idle);

    // ==================================================
    // Control
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= draw_idle;
            hold   <= 2'b00;
            second <= 1'b0;
            cnt    <= 4'd0;
            rom_cs <= 1'b0;
            wr_en  <= 1'b0;
        end else begin
            hold  <= hold >> 1;
            wr_en <= emit;
            case (state)
                draw_idle: begin
                    rom_cs <= 1'b0;
                    if (accept) begin
                        state  <= draw_fetch;
                        rom_cs <= 1'b1;
                        hold   <= 2'b11;
                        second <= 1'b0;
                    end
                end
                draw_fetch: begin
                    if (rom_good) begin
                        // Half toggles after the first word, cs drops after the second
                        if (second) begin
                            rom_cs <= 1'b0;
                        end else begin
                            hold <= 2'b11;
                        end
                        if (!blank) begin
                            cnt   <= 4'd0;
                            state <= draw_pixel;
                        end else if (second) begin
                            state <= draw_idle;
                        end else begin
                            second <= 1'b1;
                        end
                    end
                end
                draw_pixel: begin
                    // cnt 8 lets the last write leave before idle rises
                    if (cnt[3]) begin
                        if (second) begin
                            state <= draw_idle;
                        end else begin
                            second <= 1'b1;
                            state  <= draw_fetch;
                        end
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                default: begin
                    state <= draw_idle;
                end
            endcase
        end
    end

    // ==================================================
    // Data path
    // ==================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            rom_addr <= {job.code, job.vsub};
            rom_bank <= job.bank;
            rom_half <= job.hflip;
            addr     <= job.hpos;
            pal      <= job.pal;
            hflip    <= job.hflip;
        end
        if (fetch_ok) begin
            pix <= rom_data;
            if (!second) begin
                rom_half <= ~rom_half;
            end
            if (blank) begin
                addr <= addr + 9'd8;
            end
        end
        if (emit) begin
            wr.addr <= addr;
            wr.data <= {pal, pick_colour(pix, hflip)};
            addr    <= addr + 9'd1;
            // Shift in ones so the tail never looks like a colour
            pix     <= hflip ? {1'b1, pix[31:1]} : {pix[30:0], 1'b1};
        end
    end

    // Pixel writes belong to a running job
    assert property (@(posedge clk) disable iff (rst) wr_en |-> !idle)
        else $error("pixel write while the drawer is idle");

endmodule

// ==== logic/obj_line_buf.sv ====
/*
  Double-buffered object line.
  One half takes pixel writes from the drawer while the video side
  reads the other half. line_start swaps the halves. Each read returns
  the stored pixel one cycle later and leaves a transparent pixel behind.
*/
module obj_line_buf
    import obj_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       line_start,

    // Drawer side
    input  buf_wr_t    wr,
    input  logic       wr_en,

    // Video side
    input  logic       rd_en,
    input  logic [8:0] rd_addr,
    output logic [8:0] rd_pixel
);

    logic [8:0] mem [2][512];
    logic       sel;    // half being drawn, the other one is on display
    logic       keep;

    // Transparent pixels never reach the buffer
    assign keep = wr_en && (wr.data[3:0] != colour_clear);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= 1'b0;
        end else if (line_start) begin
            sel <= ~sel;
        end
    end

    // ==================================================
    // Draw half write, display half read and clear
    // ==================================================
    always_ff @(posedge clk) begin
        if (keep) begin
            mem[sel][wr.addr] <= wr.data;
        end
        if (rd_en) begin
            rd_pixel           <= mem[~sel][rd_addr];
            mem[~sel][rd_addr] <= {5'd0, colour_clear};
        end
    end

endmodule

// ==== logic/obj_render.sv ====
/*
  Object line renderer top level.
  Connects the table scanner, the tile drawer and the line buffer.
  The host loads the table and strobes each line, the ROM port serves
  tile rows and the video side reads pixels from the finished line.
*/
module obj_render
    import obj_pkg::*;
#(
    parameter int obj_count = 16,
    localparam int idx_w = $clog2(obj_count)
) (
    input  logic             clk,
    input  logic             rst,

    // Host
    input  logic             tbl_wr,
    input  logic [idx_w-1:0] tbl_idx,
    input  obj_entry_t       tbl_entry,
    input  logic             line_start,
    input  logic [8:0]       line,
    output logic             line_done,

    // Graphics ROM
    output logic [19:0]      rom_addr,
    output logic [1:0]       rom_bank,
    output logic             rom_half,
    output logic             rom_cs,
    input  logic [31:0]      rom_data,
    input  logic             rom_ok,

    // Video
    input  logic             rd_en,
    input  logic [8:0]       rd_addr,
    output logic [8:0]       rd_pixel
);

    logic     start;
    logic     idle;
    obj_job_t job;
    buf_wr_t  wr;
    logic     wr_en;

    obj_scan #(
        .obj_count (obj_count)
    ) i_scan (
        .clk        (clk),
        .rst        (rst),
        .tbl_wr     (tbl_wr),
        .tbl_idx    (tbl_idx),
        .tbl_entry  (tbl_entry),
        .line_start (line_start),
        .line       (line),
        .idle       (idle),
        .start      (start),
        .job        (job),
        .line_done  (line_done)
    );

    obj_draw i_draw (
        .clk      (clk),
        .rst      (rst),
        .job      (job),
        .start    (start),
        .idle     (idle),
        .wr       (wr),
        .wr_en    (wr_en),
        .rom_addr (rom_addr),
        .rom_bank (rom_bank),
        .rom_half (rom_half),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    obj_line_buf i_buf (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .wr         (wr),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_pixel   (rd_pixel)
    );

endmodule

// ==== test/obj_checker.sv ====
/*
  Testbench checker for the object line renderer.
  Mirrors the host table writes, snapshots the table and line on each
  line_start and predicts every pixel of the displayed line from the
  tile rules. Holds the graphics ROM contents used by the ROM model.
*/
module obj_checker
    import obj_pkg::*;
#(
    parameter int obj_count = 16,
    localparam int idx_w = $clog2(obj_count)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             tbl_wr,
    input  logic [idx_w-1:0] tbl_idx,
    input  obj_entry_t       tbl_entry,
    input  logic             line_start,
    input  logic [8:0]       line,
    input  logic             rd_en,
    input  logic [8:0]       rd_addr,
    input  logic [8:0]       rd_pixel,
    output int               errors,
    output int               pixels_checked
);
    timeunit 1ns;
    timeprecision 100ps;

    obj_entry_t tbl_copy [obj_count];
    obj_entry_t draw_tbl [obj_count];
    obj_entry_t disp_tbl [obj_count];
    logic [8:0] draw_line;
    logic [8:0] disp_line;
    int         lines_seen;
    logic       rd_en_q;
    logic [8:0] rd_addr_q;
    logic [8:0] exp_pix;

    // ROM contents, some rows come back all ones
    function automatic logic [31:0] rom_word(input logic [1:0] bank, input logic [19:0] addr,
                                             input logic half);
        logic [31:0] h;
        if (addr[1:0] == 2'b11 && (half || addr[4])) begin
            return 32'hffff_ffff;
        end
        h = {9'd0, bank, addr, half} * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca77;
        h = h ^ (h >> 13);
        return h;
    endfunction

    // Pixel i of a word, one bit from each byte
    function automatic logic [3:0] pixel_colour(input logic [31:0] w, input logic flip,
                                                input logic [2:0] i);
        logic [4:0] s;
        s = {2'b00, i};
        if (flip) begin
            return {w[5'd24 + s], w[5'd16 + s], w[5'd8 + s], w[s]};
        end
        return {w[5'd31 - s], w[5'd23 - s], w[5'd15 - s], w[5'd7 - s]};
    endfunction

    // ==================================================
    // Reference line model
    // ==================================================
    function automatic logic [8:0] ref_pixel(input logic [8:0] x);
        logic [8:0]  result;
        logic [8:0]  vdiff;
        logic [8:0]  hoff;
        logic [31:0] w;
        logic [3:0]  c;
        obj_entry_t  e;
        result = {5'd0, colour_clear};
        // Later entries are drawn later and cover earlier ones
        for (int i = 0; i < obj_count; i++) begin
            e     = disp_tbl[idx_w'(i)];
            vdiff = disp_line - e.vpos;
            hoff  = x - e.hpos;
            if (vdiff < 9'd16 && hoff < 9'd16 && e.hpos > hpos_min && e.hpos < hpos_max) begin
                w = rom_word(e.bank, {e.code, vdiff[3:0]}, e.hflip ^ hoff[3]);
                c = pixel_colour(w, e.hflip, hoff[2:0]);
                if (c != colour_clear) begin
                    result = {e.pal, c};
                end
            end
        end
        return result;
    endfunction

    always @(posedge clk) begin
        if (tbl_wr) begin
            tbl_copy[tbl_idx] <= tbl_entry;
        end
        if (line_start) begin
            draw_tbl  <= tbl_copy;
            draw_line <= line;
            disp_tbl  <= draw_tbl;
            disp_line <= draw_line;
        end
    end

    // ==================================================
    // Readout compare
    // ==================================================
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            lines_seen     <= 0;
            rd_en_q        <= 1'b0;
            rd_addr_q      <= '0;
            errors         <= 0;
            pixels_checked <= 0;
        end else begin
            rd_en_q   <= rd_en;
            rd_addr_q <= rd_addr;
            if (line_start) begin
                lines_seen <= lines_seen + 1;
            end
            // Half shown after the first line_start still holds power-up contents
            if (rd_en_q && lines_seen >= 2) begin
                exp_pix = ref_pixel(rd_addr_q);
                pixels_checked <= pixels_checked + 1;
                if (rd_pixel !== exp_pix) begin
                    errors <= errors + 1;
                    $display("error rd_pixel addr %h expected %h got %h",
                             rd_addr_q, exp_pix, rd_pixel);
                end
            end
        end
    end

endmodule

// ==== test/tb_obj_render.sv ====
/*
  Testbench top for the object line renderer.
  Loads random object tables, strobes each line and reads the finished
  line back while the next one draws. A ROM model answers the drawer
  with random latency and the checker compares every pixel read.
*/
module tb_obj_render
    import obj_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int obj_count = 16;
    localparam int idx_w = $clog2(obj_count);
    localparam int num_lines = 24;
    localparam int watchdog_cycles = (num_lines + 2) * (obj_count * 40 + 600);

    localparam int mode_full = 0;
    localparam int mode_empty = 1;
    localparam int mode_outside = 2;

    logic             clk = 1'b0;
    logic             rst;
    logic             tbl_wr;
    logic [idx_w-1:0] tbl_idx;
    obj_entry_t       tbl_entry;
    logic             line_start;
    logic [8:0]       line;
    logic             line_done;
    logic [19:0]      rom_addr;
    logic [1:0]       rom_bank;
    logic             rom_half;
    logic             rom_cs;
    logic [31:0]      rom_data = '0;
    logic             rom_ok = 1'b0;
    logic             rd_en;
    logic [8:0]       rd_addr;
    logic [8:0]       rd_pixel;

    logic [23:0]      rom_req_q;
    int               rom_wait;
    logic [8:0]       cur_line;
    int               check_errors;
    int               check_pixels;
    int               total_errors;

    always #2 clk = ~clk;

    obj_render #(
        .obj_count (obj_count)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .tbl_wr     (tbl_wr),
        .tbl_idx    (tbl_idx),
        .tbl_entry  (tbl_entry),
        .line_start (line_start),
        .line       (line),
        .line_done  (line_done),
        .rom_addr   (rom_addr),
        .rom_bank   (rom_bank),
        .rom_half   (rom_half),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_pixel   (rd_pixel)
    );

    obj_checker #(
        .obj_count (obj_count)
    ) i_check (
        .clk            (clk),
        .rst            (rst),
        .tbl_wr         (tbl_wr),
        .tbl_idx        (tbl_idx),
        .tbl_entry      (tbl_entry),
        .line_start     (line_start),
        .line           (line),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .rd_pixel       (rd_pixel),
        .errors         (check_errors),
        .pixels_checked (check_pixels)
    );

    // ==================================================
    // Graphics ROM model
    // ==================================================
    // Every new address restarts a random 1 to 6 cycle wait for rom_ok
    always @(posedge clk) begin
        if (rst) begin
            rom_ok    <= 1'b0;
            rom_req_q <= '0;
            rom_wait  <= 0;
        end else if (!rom_cs) begin
            rom_ok    <= 1'b0;
            rom_req_q <= '0;
        end else begin
            rom_data <= i_check.rom_word(rom_bank, rom_addr, rom_half);
            if ({rom_cs, rom_bank, rom_addr, rom_half} != rom_req_q) begin
                rom_req_q <= {rom_cs, rom_bank, rom_addr, rom_half};
                rom_ok    <= 1'b0;
                rom_wait  <= int'($urandom % 6) + 1;
            end else if (rom_wait > 1) begin
                rom_wait <= rom_wait - 1;
            end else begin
                rom_ok <= 1'b1;
            end
        end
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================
    function automatic obj_entry_t random_entry(input logic [8:0] ln, input int mode);
        obj_entry_t  e;
        int unsigned r;
        int unsigned h;
        r = $urandom;
        e.code  = 16'(r);
        e.hflip = r[16];
        e.pal   = r[21:17];
        e.bank  = r[23:22];
        h = $urandom;
        if (mode == mode_empty) begin
            // Tile ends above the line or starts below it
            e.vpos = ln + 9'd1 + 9'(h % 495);
        end else begin
            e.vpos = ln - 9'(h % 24);
        end
        h = $urandom;
        if (mode == mode_outside) begin
            if (h[0]) begin
                e.hpos = 9'(h[31:8] % 49);
            end else begin
                e.hpos = hpos_max + 9'(h[31:8] % 64);
            end
        end else begin
            case (h[1:0])
                2'd0: e.hpos = 9'h40 + 9'(h[7:2]);   // Dense cluster, lots of overlap
                2'd1: begin
                    case (h[3:2])
                        2'd0: e.hpos = hpos_min;
                        2'd1: e.hpos = hpos_max;
                        2'd2: e.hpos = hpos_min + 9'd1;
                        default: e.hpos = hpos_max - 9'd1;
                    endcase
                end
                default: e.hpos = hpos_min + 9'd1 + 9'(h[31:8] % 399);
            endcase
        end
        return e;
    endfunction

    function automatic int line_mode(input int k);
        if (k % 6 == 2) begin
            return mode_empty;
        end
        if (k % 6 == 4) begin
            return mode_outside;
        end
        return mode_full;
    endfunction

    // Some lines near the top so tiles wrap from the bottom of the frame
    function automatic logic [8:0] pick_line(input int k);
        if (k % 5 == 0) begin
            return 9'($urandom % 8);
        end
        return 9'($urandom);
    endfunction

    task automatic write_table(input logic [8:0] ln, input int mode);
        obj_entry_t e;
        for (int i = 0; i < obj_count; i++) begin
            e = random_entry(ln, mode);
            @(posedge clk);
            tbl_wr    <= 1'b1;
            tbl_idx   <= idx_w'(i);
            tbl_entry <= e;
        end
        @(posedge clk);
        tbl_wr <= 1'b0;
    endtask

    task automatic start_line(input logic [8:0] ln);
        @(posedge clk);
        line_start <= 1'b1;
        line       <= ln;
        @(posedge clk);
        line_start <= 1'b0;
    endtask

    task automatic read_line();
        for (int a = 0; a < 512; a++) begin
            @(posedge clk);
            rd_en   <= 1'b1;
            rd_addr <= 9'(a);
        end
        @(posedge clk);
        rd_en <= 1'b0;
    endtask

    task automatic wait_line_done();
        @(posedge clk);
        while (!line_done) begin
            @(posedge clk);
        end
    endtask

    // Strobe a line and read the previous one while it draws
    task automatic run_line(input logic [8:0] ln);
        start_line(ln);
        fork
            read_line();
            wait_line_done();
        join
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        void'($urandom(32'he20b));
        rst        = 1'b1;
        tbl_wr     = 1'b0;
        tbl_idx    = '0;
        tbl_entry  = '0;
        line_start = 1'b0;
        line       = '0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // Clears the half on display after reset
        read_line();
        for (int k = 0; k < num_lines; k++) begin
            cur_line = pick_line(k);
            write_table(cur_line, line_mode(k));
            run_line(cur_line);
        end
        // One more empty line brings the last one to the display half
        write_table(9'd0, mode_empty);
        run_line(9'd0);
        repeat (2) @(posedge clk);
        total_errors = check_errors;
        if (check_pixels != num_lines * 512) begin
            $display("only %0d pixels were compared, %0d were expected",
                     check_pixels, num_lines * 512);
            total_errors = total_errors + 1;
        end
        $display("closing count: %0d errors, %0d pixels compared", total_errors, check_pixels);
        if (total_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, a line never finished", watchdog_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== sim.f ====
logic/obj_pkg.sv
logic/obj_scan.sv
logic/obj_draw.sv
logic/obj_line_buf.sv
logic/obj_render.sv
test/obj_checker.sv
test/tb_obj_render.sv

// ==== Makefile ====
# Verilator build and run of the object line renderer testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f sim.f --top-module tb_obj_render -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	@if grep -q "tests failed" $(LOG) || ! grep -q "all tests passed" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
